/* verilog/etx_pkg.sv */
package etx_pkg;

   // ################################################
   // Packet geometry
   // ################################################

   // Full mesh packet width on the fabric side
   localparam int PW = 104;

   // Mesh packet fields, declared top bit first
   // Bit 0 is access, srcaddr sits in the top 32 bits
   typedef struct packed {
      logic [31:0] srcaddr;
      logic [31:0] data;
      logic [31:0] dstaddr;
      logic [3:0]  ctrlmode;
      logic [1:0]  datamode;
      logic        write;
      logic        access;
   } emesh_fields_t;

   // ################################################
   // Link word sequence
   // ################################################

   // One state per link word, idle when no frame
   typedef enum logic [2:0] {
      W_IDLE,
      W_CTRL,
      W_ADDR_MID,
      W_ADDR_LO,
      W_DATA_HI,
      W_DATA_LO,
      W_SRC_HI,
      W_SRC_LO
   } tx_word_e;

   // Two bytes per cycle, high byte leaves first
   typedef logic [15:0] tx_link_word_t;

endpackage

/* verilog/etx_packet_if.sv */
`timescale 1ns/10ps

// Captured packet, held stable for the whole frame
interface etx_packet_if;

   // Disassembled fields of the packet in flight
   etx_pkg::emesh_fields_t fields;

   // Capture side owns the fields
   modport capture (
      output fields
   );

   // Serializer only reads
   modport serial (
      input fields
   );

endinterface

/* verilog/etx_packet_capture.sv */
`timescale 1ns/10ps

module etx_packet_capture (
   input  logic                    tx_lclk,
   input  logic                    ioreset,
   input  logic                    load,
   input  logic [etx_pkg::PW-1:0]  tx_packet,
   input  etx_pkg::tx_word_e       cur_word,
   etx_packet_if.capture           pkt
);

   // ################################################
   // Packet register
   // ################################################

   // Loaded on the accepting edge only
   // Fabric is free to move tx_packet afterwards
   always_ff @(posedge tx_lclk) begin
      if (load) begin
         pkt.fields <= etx_pkg::emesh_fields_t'(tx_packet);
      end
   end

   // ################################################
   // Checks
   // ################################################

   // Back-to-back loads only as a burst continuation
   // Second load must come while the last word is out
   a_load_spacing: assert property (
      @(posedge tx_lclk) disable iff (ioreset)
      load |=> (!load || cur_word == etx_pkg::W_SRC_LO)
   ) else $error("capture: load in consecutive cycles outside burst");

endmodule

/* verilog/etx_sequencer.sv */
`timescale 1ns/10ps

module etx_sequencer (
   input  logic               tx_lclk,
   input  logic               ioreset,
   input  logic               tx_access,
   input  logic               tx_burst,
   output logic               tx_io_wait,
   output logic               load,
   output etx_pkg::tx_word_e  cur_word
);

   etx_pkg::tx_word_e next_word;

   // ################################################
   // Fabric handshake
   // ################################################

   // Open to the fabric when idle
   // Also on the last word if the next packet is a burst
   assign tx_io_wait = !((cur_word == etx_pkg::W_IDLE) ||
                         (cur_word == etx_pkg::W_SRC_LO && tx_burst));

   // Single accept point for the whole design
   assign load = tx_access && !tx_io_wait;

   // ################################################
   // Word FSM
   // ################################################

   always_comb begin
      next_word = cur_word;
      case (cur_word)
         etx_pkg::W_IDLE: begin
            // New transaction starts with the control word
            if (load) begin
               next_word = etx_pkg::W_CTRL;
            end
         end
         etx_pkg::W_CTRL:     next_word = etx_pkg::W_ADDR_MID;
         etx_pkg::W_ADDR_MID: next_word = etx_pkg::W_ADDR_LO;
         etx_pkg::W_ADDR_LO:  next_word = etx_pkg::W_DATA_HI;
         etx_pkg::W_DATA_HI:  next_word = etx_pkg::W_DATA_LO;
         etx_pkg::W_DATA_LO:  next_word = etx_pkg::W_SRC_HI;
         etx_pkg::W_SRC_HI:   next_word = etx_pkg::W_SRC_LO;
         etx_pkg::W_SRC_LO: begin
            // Burst skips ctrl and address words
            if (load) begin
               next_word = etx_pkg::W_DATA_HI;
            end else begin
               next_word = etx_pkg::W_IDLE;
            end
         end
         default: next_word = etx_pkg::W_IDLE;
      endcase
   end

   always_ff @(posedge tx_lclk or posedge ioreset) begin
      if (ioreset) begin
         cur_word <= etx_pkg::W_IDLE;
      end else begin
         cur_word <= next_word;
      end
   end

   // ################################################
   // Checks
   // ################################################

   // Idle is left only through an accepted packet
   a_idle_exit: assert property (
      @(posedge tx_lclk) disable iff (ioreset)
      (cur_word == etx_pkg::W_IDLE && !load) |=> (cur_word == etx_pkg::W_IDLE)
   ) else $error("sequencer: left idle without load");

   // Fabric held off on the cycle after every accept
   a_wait_after_load: assert property (
      @(posedge tx_lclk) disable iff (ioreset)
      load |=> tx_io_wait
   ) else $error("sequencer: fabric not held off after accept");

endmodule

/* verilog/etx_serializer.sv */
`timescale 1ns/10ps

module etx_serializer (
   input  logic                   tx_lclk,
   input  logic                   ioreset,
   input  etx_pkg::tx_word_e      cur_word,
   etx_packet_if.serial           pkt,
   output etx_pkg::tx_link_word_t txo_data,
   output logic                   txo_frame
);

   etx_pkg::tx_link_word_t word_sel;

   // ################################################
   // Word mapping
   // ################################################

   // Upper byte goes on the wire first
   always_comb begin
      case (cur_word)
         etx_pkg::W_CTRL:
            word_sel = {pkt.fields.ctrlmode, pkt.fields.dstaddr[31:28],
                        ~pkt.fields.write, 7'b0};
         etx_pkg::W_ADDR_MID:
            word_sel = {pkt.fields.dstaddr[19:12], pkt.fields.dstaddr[27:20]};
         etx_pkg::W_ADDR_LO:
            word_sel = {pkt.fields.dstaddr[3:0], pkt.fields.datamode,
                        pkt.fields.write, pkt.fields.access,
                        pkt.fields.dstaddr[11:4]};
         etx_pkg::W_DATA_HI:
            word_sel = {pkt.fields.data[23:16], pkt.fields.data[31:24]};
         etx_pkg::W_DATA_LO:
            word_sel = {pkt.fields.data[7:0], pkt.fields.data[15:8]};
         etx_pkg::W_SRC_HI:
            word_sel = {pkt.fields.srcaddr[23:16], pkt.fields.srcaddr[31:24]};
         etx_pkg::W_SRC_LO:
            word_sel = {pkt.fields.srcaddr[7:0], pkt.fields.srcaddr[15:8]};
         // Idle drives zeros
         default:
            word_sel = '0;
      endcase
   end

   // ################################################
   // Link output register
   // ################################################

   // One cycle behind the sequencer state
   always_ff @(posedge tx_lclk or posedge ioreset) begin
      if (ioreset) begin
         txo_data  <= '0;
         txo_frame <= 1'b0;
      end else begin
         txo_data  <= word_sel;
         txo_frame <= (cur_word != etx_pkg::W_IDLE);
      end
   end

endmodule

/* verilog/etx_wait_sync.sv */
`timescale 1ns/10ps

module etx_wait_sync (
   input  logic tx_lclk,
   input  logic ioreset,
   input  logic txi_wr_wait,
   input  logic txi_rd_wait,
   output logic tx_wr_wait,
   output logic tx_rd_wait
);

   // Bit 0 write pushback, bit 1 read pushback
   logic [1:0] meta_q;
   logic [1:0] sync_q;

   // Remote chip pins, async to tx_lclk
   // Two flops before anything uses them
   always_ff @(posedge tx_lclk or posedge ioreset) begin
      if (ioreset) begin
         meta_q <= '0;
         sync_q <= '0;
      end else begin
         meta_q <= {txi_rd_wait, txi_wr_wait};
         sync_q <= meta_q;
      end
   end

   // Reported back to the fabric only
   assign tx_wr_wait = sync_q[0];
   assign tx_rd_wait = sync_q[1];

endmodule

/* verilog/etx_top.sv */
`timescale 1ns/10ps

module etx_top (
   input  logic                   tx_lclk,
   input  logic                   ioreset,
   // Fabric side
   input  logic [etx_pkg::PW-1:0] tx_packet,
   input  logic                   tx_access,
   input  logic                   tx_burst,
   output logic                   tx_io_wait,
   output logic                   tx_wr_wait,
   output logic                   tx_rd_wait,
   // Link pins
   output logic [15:0]            txo_data,
   output logic                   txo_frame,
   input  logic                   txi_wr_wait,
   input  logic                   txi_rd_wait
);

   logic              load;
   etx_pkg::tx_word_e cur_word;

   // Captured packet fields
   etx_packet_if pkt_if ();

   // ################################################
   // Transmit path
   // ################################################

   etx_sequencer sequencer_inst (
      .tx_lclk    (tx_lclk),
      .ioreset    (ioreset),
      .tx_access  (tx_access),
      .tx_burst   (tx_burst),
      .tx_io_wait (tx_io_wait),
      .load       (load),
      .cur_word   (cur_word)
   );

   etx_packet_capture capture_inst (
      .tx_lclk   (tx_lclk),
      .ioreset   (ioreset),
      .load      (load),
      .tx_packet (tx_packet),
      .cur_word  (cur_word),
      .pkt       (pkt_if.capture)
   );

   etx_serializer serializer_inst (
      .tx_lclk   (tx_lclk),
      .ioreset   (ioreset),
      .cur_word  (cur_word),
      .pkt       (pkt_if.serial),
      .txo_data  (txo_data),
      .txo_frame (txo_frame)
   );

   // Remote pushback back into tx_lclk
   etx_wait_sync wait_sync_inst (
      .tx_lclk     (tx_lclk),
      .ioreset     (ioreset),
      .txi_wr_wait (txi_wr_wait),
      .txi_rd_wait (txi_rd_wait),
      .tx_wr_wait  (tx_wr_wait),
      .tx_rd_wait  (tx_rd_wait)
   );

endmodule

/* tests/tb_etx.sv */
`timescale 1ns/10ps

module tb_etx;

   localparam int NUM_PKTS       = 300;
   localparam int TIMEOUT_CYCLES = NUM_PKTS * 9 + 100;

   logic                   tx_lclk;
   logic                   ioreset;
   logic [etx_pkg::PW-1:0] tx_packet;
   logic                   tx_access;
   logic                   tx_burst;
   logic                   tx_io_wait;
   logic                   tx_wr_wait;
   logic                   tx_rd_wait;
   etx_pkg::tx_link_word_t txo_data;
   logic                   txo_frame;
   logic                   txi_wr_wait;
   logic                   txi_rd_wait;

   integer seed         = 61;
   int     cyc_count    = 0;
   int     accepted_cnt = 0;
   int     word_errors  = 0;
   int     bit_errors   = 0;
   int     other_errors = 0;
   logic   accept_seen  = 1'b0;
   // Pushback history, bit 1 is two edges back
   logic [1:0] wr_hist = 2'b00;
   logic [1:0] rd_hist = 2'b00;

   // Expected link words, their kind and the cycle they are due
   etx_pkg::tx_link_word_t exp_word[$];
   etx_pkg::tx_word_e      exp_kind[$];
   int                     exp_due[$];

   etx_top etx_top_inst (
      .tx_lclk     (tx_lclk),
      .ioreset     (ioreset),
      .tx_packet   (tx_packet),
      .tx_access   (tx_access),
      .tx_burst    (tx_burst),
      .tx_io_wait  (tx_io_wait),
      .tx_wr_wait  (tx_wr_wait),
      .tx_rd_wait  (tx_rd_wait),
      .txo_data    (txo_data),
      .txo_frame   (txo_frame),
      .txi_wr_wait (txi_wr_wait),
      .txi_rd_wait (txi_rd_wait)
   );

   initial begin
      tx_lclk = 1'b0;
      forever #5 tx_lclk = ~tx_lclk;
   end

   // ################################################
   // Compare tasks
   // ################################################

   task automatic check_word(input string name, input etx_pkg::tx_link_word_t exp,
                             input etx_pkg::tx_link_word_t act);
      if (act !== exp) begin
         $display("FAILED %s (cycle %0d): expected %h, actual %h", name, cyc_count, exp, act);
         word_errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("FAILED %s (cycle %0d): expected %b, actual %b", name, cyc_count, exp, act);
         bit_errors++;
      end
   endtask

   // ################################################
   // Reference model
   // ################################################

   // Byte pairs per the link layout, first byte on the wire in hi
   function automatic etx_pkg::tx_link_word_t link_word(input etx_pkg::emesh_fields_t f,
                                                        input etx_pkg::tx_word_e kind);
      logic [7:0] hi;
      logic [7:0] lo;
      hi = 8'h00;
      lo = 8'h00;
      case (kind)
         etx_pkg::W_CTRL: begin
            hi = {f.ctrlmode, f.dstaddr[31:28]};
            lo = {~f.write, 7'b0};
         end
         etx_pkg::W_ADDR_MID: begin
            hi = f.dstaddr[19:12];
            lo = f.dstaddr[27:20];
         end
         etx_pkg::W_ADDR_LO: begin
            hi = {f.dstaddr[3:0], f.datamode, f.write, f.access};
            lo = f.dstaddr[11:4];
         end
         etx_pkg::W_DATA_HI: begin
            hi = f.data[23:16];
            lo = f.data[31:24];
         end
         etx_pkg::W_DATA_LO: begin
            hi = f.data[7:0];
            lo = f.data[15:8];
         end
         etx_pkg::W_SRC_HI: begin
            hi = f.srcaddr[23:16];
            lo = f.srcaddr[31:24];
         end
         etx_pkg::W_SRC_LO: begin
            hi = f.srcaddr[7:0];
            lo = f.srcaddr[15:8];
         end
         default: begin
            hi = 8'h00;
         end
      endcase
      return {hi, lo};
   endfunction

   // First word shows two negedges after the accept decision
   task automatic queue_packet(input etx_pkg::emesh_fields_t f, input logic burst_cont);
      etx_pkg::tx_word_e kind;
      int                due;
      kind = burst_cont ? etx_pkg::W_DATA_HI : etx_pkg::W_CTRL;
      due  = cyc_count + 2;
      repeat (burst_cont ? 4 : 7) begin
         exp_word.push_back(link_word(f, kind));
         exp_kind.push_back(kind);
         exp_due.push_back(due);
         kind = kind.next();
         due++;
      end
   endtask

   // One negedge of checking, outputs and inputs are all settled here
   task automatic model_cycle();
      etx_pkg::tx_word_e next_kind;
      logic              exp_wait;
      logic              accept;
      if (exp_due.size() != 0 && exp_due[0] == cyc_count) begin
         check_bit("frame_high", 1'b1, txo_frame);
         check_word("link_word", exp_word[0], txo_data);
         void'(exp_word.pop_front());
         void'(exp_kind.pop_front());
         void'(exp_due.pop_front());
      end else if (txo_frame) begin
         $display("ERROR: link word %h in cycle %0d was not expected", txo_data, cyc_count);
         other_errors++;
      end else begin
         check_word("idle_data", '0, txo_data);
      end
      // Remote pushback, two edges late
      check_bit("wr_wait_sync", wr_hist[1], tx_wr_wait);
      check_bit("rd_wait_sync", rd_hist[1], tx_rd_wait);
      wr_hist = {wr_hist[0], txi_wr_wait};
      rd_hist = {rd_hist[0], txi_rd_wait};
      // Word the sequencer holds now is the one due next cycle
      next_kind = etx_pkg::W_IDLE;
      if (exp_due.size() != 0 && exp_due[0] == cyc_count + 1) begin
         next_kind = exp_kind[0];
      end
      exp_wait = !(next_kind == etx_pkg::W_IDLE ||
                   (next_kind == etx_pkg::W_SRC_LO && tx_burst));
      check_bit("io_wait", exp_wait, tx_io_wait);
      accept = tx_access && !exp_wait;
      if (accept) begin
         queue_packet(etx_pkg::emesh_fields_t'(tx_packet), next_kind == etx_pkg::W_SRC_LO);
         accepted_cnt++;
      end
      accept_seen = accept;
   endtask

   always @(negedge tx_lclk) begin
      cyc_count++;
      if (ioreset) begin
         // Reset values
         check_bit("reset_frame", 1'b0, txo_frame);
         check_word("reset_data", '0, txo_data);
         check_bit("reset_wr_wait", 1'b0, tx_wr_wait);
         check_bit("reset_rd_wait", 1'b0, tx_rd_wait);
         check_bit("reset_io_wait", 1'b0, tx_io_wait);
      end else begin
         model_cycle();
      end
   end

   // ################################################
   // Stimulus
   // ################################################

   task automatic drive_inputs();
      logic [31:0]  rnd;
      logic [127:0] wide;
      rnd = $random(seed);
      txi_wr_wait = rnd[0];
      txi_rd_wait = rnd[1];
      // Pending packet stays put until taken
      if (tx_access && !accept_seen) begin
         return;
      end
      wide[31:0]   = $random(seed);
      wide[63:32]  = $random(seed);
      wide[95:64]  = $random(seed);
      wide[127:96] = $random(seed);
      tx_packet = wide[etx_pkg::PW-1:0];
      rnd = $random(seed);
      tx_access = (accepted_cnt < NUM_PKTS) && ((rnd % 32'd100) < 32'd70);
      rnd = $random(seed);
      tx_burst = (rnd % 32'd100) < 32'd40;
   endtask

   task automatic finish_run(input logic timed_out);
      if (exp_word.size() != 0) begin
         $display("ERROR: %0d expected link words were never sent", exp_word.size());
         other_errors++;
      end
      $display("Packets %0d, word errors %0d, bit errors %0d, other errors %0d",
               accepted_cnt, word_errors, bit_errors, other_errors);
      if (timed_out || (word_errors + bit_errors + other_errors) != 0) begin
         $display("TEST RESULT: FAIL");
      end else begin
         $display("TEST RESULT: PASS");
      end
      $finish;
   endtask

   initial begin
      ioreset     = 1'b1;
      tx_packet   = '0;
      tx_access   = 1'b0;
      tx_burst    = 1'b0;
      txi_wr_wait = 1'b0;
      txi_rd_wait = 1'b0;
      repeat (8) @(posedge tx_lclk);
      #1;
      ioreset = 1'b0;
      drive_inputs();
      while (accepted_cnt < NUM_PKTS || exp_word.size() != 0) begin
         @(posedge tx_lclk);
         #1;
         drive_inputs();
      end
      // Trailing idle cycles, frame must drop
      repeat (3) begin
         @(posedge tx_lclk);
         #1;
         drive_inputs();
      end
      finish_run(1'b0);
   end

   // Watchdog
   initial begin
      wait (cyc_count >= TIMEOUT_CYCLES);
      $display("ERROR: timeout after %0d cycles with %0d of %0d packets taken",
               cyc_count, accepted_cnt, NUM_PKTS);
      other_errors++;
      finish_run(1'b1);
   end

endmodule

/* list.f */
verilog/etx_pkg.sv
verilog/etx_packet_if.sv
verilog/etx_packet_capture.sv
verilog/etx_sequencer.sv
verilog/etx_serializer.sv
verilog/etx_wait_sync.sv
verilog/etx_top.sv
tests/tb_etx.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_etx
RTL_TOP   ?= etx_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/10ps
RTL_SRCS  ?= verilog/etx_pkg.sv verilog/etx_packet_if.sv verilog/etx_packet_capture.sv \
             verilog/etx_sequencer.sv verilog/etx_serializer.sv verilog/etx_wait_sync.sv \
             verilog/etx_top.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) --binary $(VFLAGS) -Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "No result line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
